// File: design/aib_pkg.sv
package aib_pkg;

	// Static configuration levels of the cell
	typedef struct packed
	{
		logic tx_en;
		logic rx_en;
		logic gen1_en;
		logic gen2_en;
		logic sdr_en;
		logic tx_async_en;
		logic rx_async_en;
		logic wkpu_en;
		logic wkpd_en;
		logic bypass_ser;
		logic compen;          // Both pad drivers on for compensation
	} cell_cfg_t;

	// Power good and strap levels
	typedef struct packed
	{
		logic pwrgood;
		logic pwrgood_io;
		logic rst_strap;
	} pwr_t;

	typedef struct packed
	{
		logic even;
		logic odd;
	} bit_pair_t;

	// Driver enables toward the pad
	typedef struct packed
	{
		logic pu_gen1;
		logic pd_gen1;
		logic pu_gen2;
		logic pd_gen2;
		logic wkpu;
		logic wkpd;
	} drv_ctrl_t;

	// Main pad and async pad as separate value and enable
	typedef struct packed
	{
		logic oe;
		logic value;
		logic async_oe;
		logic async_value;
	} pad_out_t;

	typedef enum logic [3:0]
	{
		MODE_STRAP_PD   = 4'd0,
		MODE_HIZ_PWR    = 4'd1,
		MODE_COMP       = 4'd2,
		MODE_WEAK_PU    = 4'd3,
		MODE_WEAK_PD    = 4'd4,
		MODE_WEAK_BOTH  = 4'd5,
		MODE_ASYNC_PAD  = 4'd6,   // Async data on main pad
		MODE_ASYNC_APAD = 4'd7,   // Async data on async pad
		MODE_GEN1       = 4'd8,
		MODE_GEN2       = 4'd9,
		MODE_SDR        = 4'd10,
		MODE_IDLE       = 4'd11,
		MODE_ILLEGAL    = 4'd12
	} pad_mode_e;

endpackage

// File: design/tx_serializer.sv
module tx_serializer
(
	input  logic               i_clk_1,
	input  logic               i_rst,
	input  aib_pkg::cell_cfg_t i_cfg,
	input  aib_pkg::bit_pair_t i_tx_pair,
	output logic               o_ser_bit
);

	logic               phase;
	aib_pkg::bit_pair_t cap_pair;   // Pair taken from the core side
	aib_pkg::bit_pair_t out_pair;   // Pair being sent on the pad

	// Half-rate phase
	// Held at 0 while the transmitter is off
	always_ff @(posedge i_clk_1 or negedge i_rst)
	begin
		if (!i_rst)
		begin
			phase <= 1'b0;
		end
		else if (!i_cfg.tx_en)
		begin
			phase <= 1'b0;
		end
		else
		begin
			phase <= ~phase;
		end
	end

	// Two pairs in flight
	// cap_pair waits while out_pair is on the wire
	always_ff @(posedge i_clk_1 or negedge i_rst)
	begin
		if (!i_rst)
		begin
			cap_pair <= '0;
			out_pair <= '0;
		end
		else if (!phase)
		begin
			cap_pair <= i_tx_pair;
			out_pair <= cap_pair;
		end
	end

	// Even half on phase 0, odd half on phase 1
	always_ff @(posedge i_clk_1 or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_ser_bit <= 1'b0;
		end
		else if (!phase)
		begin
			o_ser_bit <= cap_pair.even;   // Pair before the one now captured
		end
		else if (i_cfg.sdr_en)
		begin
			o_ser_bit <= out_pair.even;   // SDR repeats the even bit
		end
		else
		begin
			o_ser_bit <= out_pair.odd;
		end
	end

endmodule

// File: design/pad_drive_decode.sv
module pad_drive_decode
(
	input  logic               i_clk_1,
	input  logic               i_rst,
	input  aib_pkg::cell_cfg_t i_cfg,
	input  aib_pkg::pwr_t      i_pwr,
	input  logic               i_ser_bit,
	input  logic               i_tx_async,
	output aib_pkg::pad_out_t  o_pad,
	output aib_pkg::drv_ctrl_t o_drv,
	output aib_pkg::pad_mode_e o_mode
);

	aib_pkg::pad_mode_e mode_nxt;
	aib_pkg::drv_ctrl_t drv_nxt;
	aib_pkg::pad_out_t  pad_nxt;
	logic               sel_gen2;   // Generation used for compensation

	assign sel_gen2 = i_cfg.gen2_en & ~i_cfg.gen1_en;

	// Priority decode with the highest entry first
	always_comb
	begin
		mode_nxt = aib_pkg::MODE_ILLEGAL;
		drv_nxt = '0;
		pad_nxt = '0;
		if (i_pwr.rst_strap)
		begin
			// Strong pull-down through the gen2 driver
			mode_nxt = aib_pkg::MODE_STRAP_PD;
			drv_nxt.pd_gen2 = 1'b1;
			pad_nxt.oe = 1'b1;
		end
		else if (!i_pwr.pwrgood || !i_pwr.pwrgood_io)
		begin
			mode_nxt = aib_pkg::MODE_HIZ_PWR;
		end
		else if (!i_cfg.tx_en)
		begin
			drv_nxt.wkpu = i_cfg.wkpu_en;
			drv_nxt.wkpd = i_cfg.wkpd_en;
			if (i_cfg.wkpu_en && i_cfg.wkpd_en)
			begin
				mode_nxt = aib_pkg::MODE_WEAK_BOTH;   // Pulls fight so the pad stays undriven
			end
			else if (i_cfg.wkpu_en)
			begin
				mode_nxt = aib_pkg::MODE_WEAK_PU;
				pad_nxt.oe = 1'b1;
				pad_nxt.value = 1'b1;
			end
			else if (i_cfg.wkpd_en)
			begin
				mode_nxt = aib_pkg::MODE_WEAK_PD;
				pad_nxt.oe = 1'b1;
			end
			else
			begin
				mode_nxt = aib_pkg::MODE_IDLE;
			end
		end
		else if (i_cfg.compen)
		begin
			mode_nxt = aib_pkg::MODE_COMP;
			drv_nxt.pu_gen1 = ~sel_gen2;
			drv_nxt.pd_gen1 = ~sel_gen2;
			drv_nxt.pu_gen2 = sel_gen2;
			drv_nxt.pd_gen2 = sel_gen2;
		end
		else if (i_cfg.tx_async_en && i_cfg.bypass_ser)
		begin
			// Async level on main pad with gen1 drivers
			mode_nxt = aib_pkg::MODE_ASYNC_PAD;
			drv_nxt.pu_gen1 = i_tx_async;
			drv_nxt.pd_gen1 = ~i_tx_async;
			pad_nxt.oe = 1'b1;
			pad_nxt.value = i_tx_async;
		end
		else if (i_cfg.tx_async_en)
		begin
			mode_nxt = aib_pkg::MODE_ASYNC_APAD;
			pad_nxt.async_oe = 1'b1;
			pad_nxt.async_value = i_tx_async;
		end
		else if (i_cfg.gen1_en && !i_cfg.gen2_en && !i_cfg.sdr_en)
		begin
			mode_nxt = aib_pkg::MODE_GEN1;
			drv_nxt.pu_gen1 = i_ser_bit;
			drv_nxt.pd_gen1 = ~i_ser_bit;
			pad_nxt.oe = 1'b1;
			pad_nxt.value = i_ser_bit;
		end
		else if (i_cfg.gen2_en && !i_cfg.gen1_en && !i_cfg.sdr_en)
		begin
			mode_nxt = aib_pkg::MODE_GEN2;
			drv_nxt.pu_gen2 = i_ser_bit;
			drv_nxt.pd_gen2 = ~i_ser_bit;
			pad_nxt.oe = 1'b1;
			pad_nxt.value = i_ser_bit;
		end
		else if (i_cfg.sdr_en && i_cfg.gen1_en && !i_cfg.gen2_en)
		begin
			// SDR runs on the gen1 drivers
			mode_nxt = aib_pkg::MODE_SDR;
			drv_nxt.pu_gen1 = i_ser_bit;
			drv_nxt.pd_gen1 = ~i_ser_bit;
			pad_nxt.oe = 1'b1;
			pad_nxt.value = i_ser_bit;
		end
	end

	// All decoded outputs move together
	always_ff @(posedge i_clk_1 or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_mode <= aib_pkg::MODE_HIZ_PWR;
			o_drv <= '0;
			o_pad <= '0;
		end
		else
		begin
			o_mode <= mode_nxt;
			o_drv <= drv_nxt;
			o_pad <= pad_nxt;
		end
	end

endmodule

// File: design/rx_deserializer.sv
module rx_deserializer
(
	input  logic               i_clk_1,
	input  logic               i_rst,
	input  aib_pkg::cell_cfg_t i_cfg,
	input  logic               i_pad,
	input  logic               i_pad_async,
	output aib_pkg::bit_pair_t o_rx_pair,
	output logic               o_rx_pair_strobe,
	output logic               o_rx_async
);

	logic pad_meta;
	logic pad_sync;
	logic phase;
	logic even_hold;   // Even half waiting for its odd partner

	// Two-flop synchronizer on the pad
	always_ff @(posedge i_clk_1 or negedge i_rst)
	begin
		if (!i_rst)
		begin
			pad_meta <= 1'b0;
			pad_sync <= 1'b0;
		end
		else
		begin
			pad_meta <= i_pad;
			pad_sync <= pad_meta;
		end
	end

	always_ff @(posedge i_clk_1 or negedge i_rst)
	begin
		if (!i_rst)
		begin
			phase <= 1'b0;
		end
		else if (!i_cfg.rx_en)
		begin
			phase <= 1'b0;   // Realign when receiver comes back
		end
		else
		begin
			phase <= ~phase;
		end
	end

	always_ff @(posedge i_clk_1)
	begin
		if (!phase)
		begin
			even_hold <= pad_sync;
		end
		else
		begin
			o_rx_pair.even <= even_hold;
			o_rx_pair.odd <= pad_sync;
		end
	end

	// One pulse per completed pair
	always_ff @(posedge i_clk_1 or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_rx_pair_strobe <= 1'b0;
		end
		else
		begin
			o_rx_pair_strobe <= phase;
		end
	end

	assign o_rx_async = i_cfg.rx_async_en ? i_pad_async : 1'b0;   // Gated async path

endmodule

// File: design/aib_txrx_cell.sv
module aib_txrx_cell
(
	input  logic               i_clk_1,
	input  logic               i_rst,
	input  aib_pkg::cell_cfg_t i_cfg,
	input  aib_pkg::pwr_t      i_pwr,
	input  aib_pkg::bit_pair_t i_tx_pair,
	input  logic               i_tx_async,
	input  logic               i_pad,
	input  logic               i_pad_async,
	output aib_pkg::pad_out_t  o_pad,
	output aib_pkg::drv_ctrl_t o_drv,
	output aib_pkg::pad_mode_e o_mode,
	output aib_pkg::bit_pair_t o_rx_pair,
	output logic               o_rx_pair_strobe,
	output logic               o_rx_async
);

	logic ser_bit;   // Serial stream into the driver decode

	tx_serializer tx_serializer_inst
	(
		.i_clk_1   (i_clk_1),
		.i_rst     (i_rst),
		.i_cfg     (i_cfg),
		.i_tx_pair (i_tx_pair),
		.o_ser_bit (ser_bit)
	);

	pad_drive_decode pad_drive_decode_inst
	(
		.i_clk_1    (i_clk_1),
		.i_rst      (i_rst),
		.i_cfg      (i_cfg),
		.i_pwr      (i_pwr),
		.i_ser_bit  (ser_bit),
		.i_tx_async (i_tx_async),
		.o_pad      (o_pad),
		.o_drv      (o_drv),
		.o_mode     (o_mode)
	);

	// Receive side sees the resolved pad directly
	rx_deserializer rx_deserializer_inst
	(
		.i_clk_1          (i_clk_1),
		.i_rst            (i_rst),
		.i_cfg            (i_cfg),
		.i_pad            (i_pad),
		.i_pad_async      (i_pad_async),
		.o_rx_pair        (o_rx_pair),
		.o_rx_pair_strobe (o_rx_pair_strobe),
		.o_rx_async       (o_rx_async)
	);

endmodule

// File: sim/tb_clock_gen.sv
module tb_clock_gen
(
	output logic o_clk_1
);

	// Period of 4
	initial
	begin
		o_clk_1 = 1'b0;
		forever
		begin
			#2 o_clk_1 = ~o_clk_1;
		end
	end

endmodule

// File: sim/tb_aib_txrx_cell.sv
module tb_aib_txrx_cell;

	localparam int K_GEN1 = 0;
	localparam int K_GEN2 = 1;
	localparam int K_SDR = 2;
	localparam int K_PRIO = 3;
	localparam int K_ASYNC = 4;
	localparam int K_RXONLY = 5;
	localparam int K_RXOFF = 6;

	logic               clk_1;
	logic               rst;
	aib_pkg::cell_cfg_t cfg;
	aib_pkg::pwr_t      pwr;
	aib_pkg::bit_pair_t tx_pair;
	logic               tx_async;
	logic               pad;
	logic               pad_async;
	aib_pkg::pad_out_t  pad_out;
	aib_pkg::drv_ctrl_t drv;
	aib_pkg::pad_mode_e mode;
	aib_pkg::bit_pair_t rx_pair;
	logic               rx_strobe;
	logic               rx_async;

	// Reference model registers
	logic               m_tx_phase;
	aib_pkg::bit_pair_t m_cap;
	aib_pkg::bit_pair_t m_out;
	logic               m_ser;
	aib_pkg::pad_mode_e m_mode;
	aib_pkg::drv_ctrl_t m_drv;
	aib_pkg::pad_out_t  m_pad;
	logic               m_meta;
	logic               m_sync;
	logic               m_rx_phase;
	logic               m_even;
	aib_pkg::bit_pair_t m_pair;
	logic               m_pair_valid;   // Pair register unknown until first load
	logic               m_strobe;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          strobes;
	logic        ok;

	tb_clock_gen tb_clock_gen_inst
	(
		.o_clk_1 (clk_1)
	);

	aib_txrx_cell aib_txrx_cell_inst
	(
		.i_clk_1          (clk_1),
		.i_rst            (rst),
		.i_cfg            (cfg),
		.i_pwr            (pwr),
		.i_tx_pair        (tx_pair),
		.i_tx_async       (tx_async),
		.i_pad            (pad),
		.i_pad_async      (pad_async),
		.o_pad            (pad_out),
		.o_drv            (drv),
		.o_mode           (mode),
		.o_rx_pair        (rx_pair),
		.o_rx_pair_strobe (rx_strobe),
		.o_rx_async       (rx_async)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Priority table with the highest entry first
	function automatic aib_pkg::pad_mode_e expect_mode(input aib_pkg::cell_cfg_t c,
		input aib_pkg::pwr_t p);
		if (p.rst_strap)
			return aib_pkg::MODE_STRAP_PD;
		if (!(p.pwrgood && p.pwrgood_io))
			return aib_pkg::MODE_HIZ_PWR;
		if (!c.tx_en)
		begin
			if (c.wkpu_en && c.wkpd_en)
				return aib_pkg::MODE_WEAK_BOTH;
			if (c.wkpu_en)
				return aib_pkg::MODE_WEAK_PU;
			if (c.wkpd_en)
				return aib_pkg::MODE_WEAK_PD;
			return aib_pkg::MODE_IDLE;
		end
		if (c.compen)
			return aib_pkg::MODE_COMP;
		if (c.tx_async_en)
			return c.bypass_ser ? aib_pkg::MODE_ASYNC_PAD : aib_pkg::MODE_ASYNC_APAD;
		case ({c.gen1_en, c.gen2_en, c.sdr_en})
			3'b100: return aib_pkg::MODE_GEN1;
			3'b010: return aib_pkg::MODE_GEN2;
			3'b101: return aib_pkg::MODE_SDR;
			default: return aib_pkg::MODE_ILLEGAL;
		endcase
	endfunction

	task automatic model_reset();
		m_tx_phase = 1'b0;
		m_cap = '0;
		m_out = '0;
		m_ser = 1'b0;
		m_mode = aib_pkg::MODE_HIZ_PWR;
		m_drv = '0;
		m_pad = '0;
		m_meta = 1'b0;
		m_sync = 1'b0;
		m_rx_phase = 1'b0;
		m_pair_valid = 1'b0;
		m_strobe = 1'b0;
	endtask

	// One rising edge of the whole cell
	task automatic model_step();
		aib_pkg::pad_mode_e md;
		logic               use_gen2;
		md = expect_mode(cfg, pwr);
		use_gen2 = cfg.gen2_en && !cfg.gen1_en;
		m_mode = md;
		m_drv = '0;
		m_pad = '0;
		if (md inside {aib_pkg::MODE_WEAK_PU, aib_pkg::MODE_WEAK_PD, aib_pkg::MODE_WEAK_BOTH,
			aib_pkg::MODE_IDLE})
		begin
			m_drv.wkpu = cfg.wkpu_en;
			m_drv.wkpd = cfg.wkpd_en;
		end
		case (md)
			aib_pkg::MODE_STRAP_PD:
			begin
				m_drv.pd_gen2 = 1'b1;
				m_pad.oe = 1'b1;
			end
			aib_pkg::MODE_WEAK_PU: m_pad = 4'b1100;   // oe and value high
			aib_pkg::MODE_WEAK_PD: m_pad.oe = 1'b1;
			aib_pkg::MODE_COMP:
			begin
				{m_drv.pu_gen2, m_drv.pd_gen2} = {2{use_gen2}};
				{m_drv.pu_gen1, m_drv.pd_gen1} = {2{!use_gen2}};
			end
			aib_pkg::MODE_ASYNC_PAD:
			begin
				{m_drv.pu_gen1, m_drv.pd_gen1} = {tx_async, !tx_async};
				{m_pad.oe, m_pad.value} = {1'b1, tx_async};
			end
			aib_pkg::MODE_ASYNC_APAD: {m_pad.async_oe, m_pad.async_value} = {1'b1, tx_async};
			aib_pkg::MODE_GEN1, aib_pkg::MODE_SDR:
			begin
				{m_drv.pu_gen1, m_drv.pd_gen1} = {m_ser, !m_ser};
				{m_pad.oe, m_pad.value} = {1'b1, m_ser};
			end
			aib_pkg::MODE_GEN2:
			begin
				{m_drv.pu_gen2, m_drv.pd_gen2} = {m_ser, !m_ser};
				{m_pad.oe, m_pad.value} = {1'b1, m_ser};
			end
			default: m_pad = '0;
		endcase
		// Serializer sends the older captured pair first
		if (!m_tx_phase)
		begin
			m_ser = m_cap.even;
			m_out = m_cap;
			m_cap = tx_pair;
		end
		else
		begin
			m_ser = cfg.sdr_en ? m_out.even : m_out.odd;
		end
		m_tx_phase = cfg.tx_en ? !m_tx_phase : 1'b0;
		// Deserializer behind the synchronizer
		m_strobe = m_rx_phase;
		if (!m_rx_phase)
		begin
			m_even = m_sync;
		end
		else
		begin
			m_pair = {m_even, m_sync};
			m_pair_valid = 1'b1;
		end
		m_sync = m_meta;
		m_meta = pad;
		m_rx_phase = cfg.rx_en ? !m_rx_phase : 1'b0;
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		check_val("o_mode", 32'(mode), 32'(m_mode));
		check_val("o_drv", 32'(drv), 32'(m_drv));
		check_val("o_pad", 32'(pad_out), 32'(m_pad));
		check_val("o_rx_pair_strobe", 32'(rx_strobe), 32'(m_strobe));
		check_val("o_rx_async", 32'(rx_async), 32'(cfg.rx_async_en & pad_async));
		if (m_pair_valid)
			check_val("o_rx_pair", 32'(rx_pair), 32'(m_pair));
	endtask

	task automatic drive_inputs(input int kind, input int cyc);
		logic [31:0] r;
		if (cyc % 8 == 0)
		begin
			pwr = 3'b110;
			cfg = '0;
			{cfg.tx_en, cfg.rx_en} = 2'b11;
			case (kind)
				K_GEN1: cfg.gen1_en = 1'b1;
				K_GEN2: cfg.gen2_en = 1'b1;
				K_SDR: {cfg.gen1_en, cfg.sdr_en} = 2'b11;
				K_ASYNC:
				begin
					take_bits(2, r);
					{cfg.tx_async_en, cfg.bypass_ser, cfg.rx_async_en} = {1'b1, r[1:0]};
				end
				K_RXONLY: cfg.tx_en = 1'b0;
				K_RXOFF: cfg = '0;
				default:
				begin
					// Random levels biased toward powered transmit
					take_bits(14, r);
					cfg = aib_pkg::cell_cfg_t'(r[10:0]);
					cfg.tx_en = r[10] | r[11];
					cfg.compen = cfg.compen & r[12];
					cfg.tx_async_en = cfg.tx_async_en & r[13];
					take_bits(6, r);
					pwr.rst_strap = r[0] & r[1];
					pwr.pwrgood = r[2] | r[3];
					pwr.pwrgood_io = r[4] | r[5];
				end
			endcase
		end
		take_bits(5, r);
		tx_pair = aib_pkg::bit_pair_t'(r[1:0]);
		tx_async = r[2];
		// A driven pad wins over the far side
		pad = pad_out.oe ? pad_out.value : r[3];
		pad_async = pad_out.async_oe ? pad_out.async_value : r[4];
	endtask

	task automatic step_cycle(input int kind, input int cyc);
		@(posedge clk_1);
		#1;
		model_step();
		check_outputs();
		if (kind == K_RXOFF && cyc >= 2)
			check_val("o_rx_pair_strobe", 32'(rx_strobe), 32'd0);   // Strobe stops
		if (rx_strobe)
			strobes++;
		drive_inputs(kind, cyc);
	endtask

	task automatic run(input int kind, input int n);
		for (int i = 0; i < n; i++)
			step_cycle(kind, i);
	endtask

	task automatic wait_strobe(input int kind, input int limit, output logic found);
		found = 1'b0;
		for (int i = 1; i <= limit && !found; i++)
		begin
			step_cycle(kind, i);
			found = rx_strobe;
		end
		assert (found)
		else
		begin
			errors++;
			$display("timeout while waiting for o_rx_pair_strobe at %0t", $time);
		end
	endtask

	initial
	begin
		lfsr = 32'h5530;
		errors = 0;
		checks = 0;
		strobes = 0;
		rst = 1'b0;
		cfg = '0;
		pwr = 3'b110;
		tx_pair = '0;
		tx_async = 1'b0;
		pad = 1'b0;
		pad_async = 1'b0;
		for (int i = 0; i < 16; i++)
		begin
			@(posedge clk_1);
			#1;
			check_val("o_mode", 32'(mode), 32'(aib_pkg::MODE_HIZ_PWR));
			check_val("o_drv", 32'(drv), 32'd0);
			check_val("o_pad", 32'(pad_out), 32'd0);
			check_val("o_rx_pair_strobe", 32'(rx_strobe), 32'd0);
		end
		rst = 1'b1;
		model_reset();
		drive_inputs(K_GEN1, 0);
		wait_strobe(K_GEN1, 16, ok);
		if (ok)
		begin
			strobes = 0;
			run(K_GEN1, 200);
			assert (strobes > 0)
			else
			begin
				errors++;
				$display("no receive strobe seen during the loopback run");
			end
			run(K_GEN2, 96);
			run(K_SDR, 96);
			run(K_PRIO, 320);
			run(K_ASYNC, 128);
			run(K_RXONLY, 8);
			wait_strobe(K_RXONLY, 16, ok);
		end
		if (ok)
		begin
			run(K_RXONLY, 200);
			run(K_RXOFF, 12);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: project.f
design/aib_pkg.sv
design/tx_serializer.sv
design/pad_drive_decode.sv
design/rx_deserializer.sv
design/aib_txrx_cell.sv
sim/tb_clock_gen.sv
sim/tb_aib_txrx_cell.sv

// File: Makefile
TOP = tb_aib_txrx_cell

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
